// ==== common/cipher_ctrl_pkg.sv ====
/*
 * Shared definitions for the cipher round controller: sparse booleans,
 * cipher operation and key length encodings, datapath selectors and the
 * round counter type. Imported by every controller module.
 */
package cipher_ctrl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sparse booleans
  ////////////////////////////////////////////////////////////////////////////

  parameter int Sp2VWidth = 3;

  // Only these two patterns are legal, the rest flag a fault
  typedef enum logic [Sp2VWidth-1:0] {
    SP2V_HIGH = 3'b011,
    SP2V_LOW  = 3'b100
  } sp2v_e;

  // Bit i set means rail i is active high
  parameter logic [Sp2VWidth-1:0] SP2V_LOGIC_HIGH = 3'b011;

  ////////////////////////////////////////////////////////////////////////////
  // Cipher configuration
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    CIPH_FWD = 2'b01,
    CIPH_INV = 2'b10
  } ciph_op_e;

  // One-hot key length
  typedef enum logic [2:0] {
    AES_128 = 3'b001,
    AES_192 = 3'b010,
    AES_256 = 3'b100
  } key_len_e;

  parameter int RndCtrWidth = 4;
  typedef logic [RndCtrWidth-1:0] rnd_ctr_t;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath selectors
  ////////////////////////////////////////////////////////////////////////////

  // Pairwise Hamming distance 2
  typedef enum logic [2:0] {
    STATE_INIT  = 3'b110,
    STATE_ROUND = 3'b011,
    STATE_CLEAR = 3'b101
  } state_sel_e;

  typedef enum logic [2:0] {
    ADD_RK_INIT  = 3'b110,
    ADD_RK_ROUND = 3'b011,
    ADD_RK_FINAL = 3'b101
  } add_rk_sel_e;

  typedef enum logic [1:0] {
    ROUND_KEY_DIRECT = 2'b01,
    ROUND_KEY_MIXED  = 2'b10   // Inverse middle rounds
  } round_key_sel_e;

  typedef struct packed {
    state_sel_e     state_sel;
    add_rk_sel_e    add_rk_sel;
    round_key_sel_e round_key_sel;
  } ciph_sel_t;

endpackage

// ==== cipher_ctrl/sp2v_check.sv ====
`timescale 1ns/1ps

/*
 * Encoding check for a vector of sparse booleans. Signals pass through
 * unchanged and err_o rises if any of them is neither high nor low.
 */
module sp2v_check #(
  parameter int unsigned Num = 1
) (
  input  cipher_ctrl_pkg::sp2v_e [Num-1:0] sig_i,
  output cipher_ctrl_pkg::sp2v_e [Num-1:0] sig_o,
  output logic                             err_o
);

  import cipher_ctrl_pkg::*;

  logic [Num-1:0] sig_err;

  for (genvar i = 0; i < Num; i++) begin : gen_chk
    // Rails still see the raw bits, the fault path stops them
    assign sig_o[i]   = sig_i[i];
    assign sig_err[i] = !(sig_i[i] inside {SP2V_HIGH, SP2V_LOW});
  end

  assign err_o = |sig_err;

endmodule

// ==== cipher_ctrl/rail_or_check.sv ====
`timescale 1ns/1ps

/*
 * Merges one payload from all FSM rails by OR and flags any rail whose
 * value differs from the merged result. Used once per payload type.
 */
module rail_or_check #(
  parameter type         payload_t = logic,
  parameter int unsigned NumRails  = 3
) (
  input  payload_t rails_i [NumRails],
  output payload_t comb_o,
  output logic     err_o
);

  payload_t comb;
  logic     err;

  // One rail is enough to set a bit
  always_comb begin : or_rails
    comb = payload_t'('0);
    for (int unsigned i = 0; i < NumRails; i++) begin
      comb = payload_t'(comb | rails_i[i]);
    end
  end

  // A valid but disagreeing rail would slip past any encoding check
  always_comb begin : cmp_rails
    err = 1'b0;
    for (int unsigned i = 0; i < NumRails; i++) begin
      err = err | (rails_i[i] != comb);
    end
  end

  assign comb_o = comb;
  assign err_o  = err;

  // All rails come out of reset known, so X here means a dead rail
  always_comb begin : err_known
    err_known_a: assert final (!$isunknown(err));
  end

endmodule

// ==== cipher_ctrl/cipher_rail_fsm.sv ====
`timescale 1ns/1ps

/*
 * One rail of the round-sequencing FSM. The top runs three in lockstep,
 * each on one bit of every sparse signal. With ActiveHigh = 0 the rail
 * bits are inverted on the way in and out.
 */
module cipher_rail_fsm #(
  parameter bit ActiveHigh    = 1'b1,
  parameter bit CiphOpFwdOnly = 1'b0
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  // Rail bits of the sparse inputs
  input  logic                       in_valid_i,
  input  logic                       crypt_i,
  input  logic                       out_ready_i,
  input  logic                       crypt_q_i,

  input  logic                       cfg_valid_i,
  input  cipher_ctrl_pkg::ciph_op_e  op_i,
  input  cipher_ctrl_pkg::key_len_e  key_len_i,
  input  logic                       fault_i,     // Encoding or rail mismatch

  // Rail bits of the sparse outputs
  output logic                       in_ready_o,
  output logic                       out_valid_o,
  output logic                       state_we_o,
  output logic                       crypt_d_o,

  output cipher_ctrl_pkg::ciph_sel_t sel_o,
  output cipher_ctrl_pkg::rnd_ctr_t  rnd_ctr_o,
  output logic                       alert_o
);

  import cipher_ctrl_pkg::*;

  // Any two states differ in at least 3 bits
  typedef enum logic [5:0] {
    ST_IDLE   = 6'b001110,
    ST_INIT   = 6'b010101,
    ST_ROUND  = 6'b100011,
    ST_FINAL  = 6'b111000,
    ST_OUTPUT = 6'b010010,
    ST_ERROR  = 6'b101101
  } rail_state_e;

  rail_state_e state_d, state_q;
  rnd_ctr_t    rnd_ctr_d, rnd_ctr_q;
  ciph_op_e    op_d, op_q;
  key_len_e    key_len_d, key_len_q;
  rnd_ctr_t    last_rnd;     // Nr-1
  logic        key_len_ok;

  logic in_valid, crypt, out_ready, crypt_q;
  logic in_ready, out_valid, state_we, crypt_d;
  logic op_err, key_len_err, busy, busy_err;

  // Map rail bits to logic values
  assign in_valid  = ActiveHigh ? in_valid_i  : ~in_valid_i;
  assign crypt     = ActiveHigh ? crypt_i     : ~crypt_i;
  assign out_ready = ActiveHigh ? out_ready_i : ~out_ready_i;
  assign crypt_q   = ActiveHigh ? crypt_q_i   : ~crypt_q_i;

  assign op_err      = cfg_valid_i && !(op_i inside {CIPH_FWD, CIPH_INV});
  assign key_len_err = !(key_len_i inside {AES_128, AES_192, AES_256});

  // Last middle round for the captured key length
  always_comb begin : last_rnd_decode
    key_len_ok = 1'b1;
    case (key_len_q)
      AES_128: last_rnd = rnd_ctr_t'(9);
      AES_192: last_rnd = rnd_ctr_t'(11);
      AES_256: last_rnd = rnd_ctr_t'(13);
      default: begin
        last_rnd   = rnd_ctr_t'(9);
        key_len_ok = 1'b0;
      end
    endcase
  end

  // While a block is in flight the status must read busy
  assign busy     = state_q inside {ST_INIT, ST_ROUND, ST_FINAL, ST_OUTPUT};
  assign busy_err = busy && (!crypt_q || !key_len_ok);

  ////////////////////////////////////////////////////////////////////////////
  // Next state and outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : fsm_comb
    state_d   = state_q;
    rnd_ctr_d = rnd_ctr_q;
    op_d      = op_q;
    key_len_d = key_len_q;
    crypt_d   = crypt_q;
    in_ready  = 1'b0;
    out_valid = 1'b0;
    state_we  = 1'b0;
    alert_o   = 1'b0;
    sel_o     = '{state_sel:     STATE_CLEAR,
                  add_rk_sel:    ADD_RK_INIT,
                  round_key_sel: ROUND_KEY_DIRECT};

    case (state_q)
      ST_IDLE: begin
        in_ready = crypt;                     // Ready once a run is requested
        if (in_valid && crypt && cfg_valid_i) begin
          if (key_len_err) begin
            state_d = ST_ERROR;
          end else begin
            op_d      = op_i;
            key_len_d = key_len_i;
            rnd_ctr_d = '0;
            crypt_d   = 1'b1;
            state_d   = ST_INIT;
          end
        end
      end

      ST_INIT: begin
        state_we             = 1'b1;
        sel_o.state_sel      = STATE_INIT;
        sel_o.add_rk_sel     = ADD_RK_INIT;
        rnd_ctr_d            = rnd_ctr_t'(1);
        state_d              = ST_ROUND;    // Nr >= 10, never skips rounds
      end

      ST_ROUND: begin
        state_we         = 1'b1;
        sel_o.state_sel  = STATE_ROUND;
        sel_o.add_rk_sel = ADD_RK_ROUND;
        if (op_q == CIPH_INV && !CiphOpFwdOnly) begin
          sel_o.round_key_sel = ROUND_KEY_MIXED;
        end
        if (rnd_ctr_q == last_rnd) begin
          state_d = ST_FINAL;
        end else begin
          rnd_ctr_d = rnd_ctr_q + rnd_ctr_t'(1);
        end
      end

      ST_FINAL: begin
        state_we         = 1'b1;
        sel_o.state_sel  = STATE_ROUND;
        sel_o.add_rk_sel = ADD_RK_FINAL;
        rnd_ctr_d        = '0;
        state_d          = ST_OUTPUT;
      end

      // Hold the result until the consumer takes it
      ST_OUTPUT: begin
        out_valid = !fault_i;
        if (out_ready) begin
          crypt_d = 1'b0;
          state_d = ST_IDLE;
        end
      end

      // Terminal, left only through reset
      ST_ERROR: begin
        alert_o = 1'b1;
        crypt_d = 1'b0;
      end

      default: state_d = ST_ERROR;
    endcase

    if (fault_i || op_err || busy_err) begin
      state_d = ST_ERROR;
      crypt_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : fsm_reg
    if (!rst_ni) begin
      state_q   <= ST_IDLE;
      rnd_ctr_q <= '0;
      op_q      <= CIPH_FWD;
      key_len_q <= AES_128;
    end else begin
      state_q   <= state_d;
      rnd_ctr_q <= rnd_ctr_d;
      op_q      <= op_d;
      key_len_q <= key_len_d;
    end
  end

  // Back to rail polarity
  assign in_ready_o  = ActiveHigh ? in_ready  : ~in_ready;
  assign out_valid_o = ActiveHigh ? out_valid : ~out_valid;
  assign state_we_o  = ActiveHigh ? state_we  : ~state_we;
  assign crypt_d_o   = ActiveHigh ? crypt_d   : ~crypt_d;
  assign rnd_ctr_o   = rnd_ctr_q;

  // Longest schedule (AES-256) stops counting at 13
  rnd_ctr_max_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rnd_ctr_q <= rnd_ctr_t'(13));

endmodule

// ==== cipher_ctrl/cipher_ctrl_top.sv ====
`timescale 1ns/1ps

/*
 * Round-sequencing controller for the cipher datapath. Three FSM rails
 * run on the sparse handshake bits, combiners and checkers merge them,
 * and the busy status register lives here.
 */
module cipher_ctrl_top #(
  parameter bit CiphOpFwdOnly = 1'b0
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  // Input handshake
  input  cipher_ctrl_pkg::sp2v_e     in_valid_i,
  output cipher_ctrl_pkg::sp2v_e     in_ready_o,

  // Output handshake
  output cipher_ctrl_pkg::sp2v_e     out_valid_o,
  input  cipher_ctrl_pkg::sp2v_e     out_ready_i,

  // Configuration and status
  input  logic                       cfg_valid_i,
  input  cipher_ctrl_pkg::ciph_op_e  op_i,
  input  cipher_ctrl_pkg::key_len_e  key_len_i,
  input  cipher_ctrl_pkg::sp2v_e     crypt_i,
  output cipher_ctrl_pkg::sp2v_e     crypt_o,

  // Datapath control
  output cipher_ctrl_pkg::sp2v_e     state_we_o,
  output cipher_ctrl_pkg::ciph_sel_t sel_o,
  output cipher_ctrl_pkg::rnd_ctr_t  rnd_ctr_o,
  output logic                       alert_o
);

  import cipher_ctrl_pkg::*;

  localparam int unsigned NumChk = 4;

  sp2v_e [NumChk-1:0]   chk_in;
  sp2v_e [NumChk-1:0]   chk_out;
  logic                 sp_enc_err;
  logic                 sel_err;
  logic                 ctr_err;
  logic                 fault;
  logic [Sp2VWidth-1:0] crypt_q_raw;

  // One bit per rail
  logic [Sp2VWidth-1:0] sp_in_valid, sp_out_ready, sp_crypt, sp_crypt_q;
  logic [Sp2VWidth-1:0] sp_in_ready, sp_out_valid, sp_state_we, sp_crypt_d;
  logic [Sp2VWidth-1:0] mr_alert;

  // Full payload per rail, merged below
  ciph_sel_t mr_sel     [Sp2VWidth];
  rnd_ctr_t  mr_rnd_ctr [Sp2VWidth];

  ////////////////////////////////////////////////////////////////////////////
  // Sparse input checks
  ////////////////////////////////////////////////////////////////////////////

  assign chk_in[0] = in_valid_i;
  assign chk_in[1] = out_ready_i;
  assign chk_in[2] = crypt_i;
  assign chk_in[3] = sp2v_e'(crypt_q_raw);

  sp2v_check #(
    .Num ( NumChk )
  ) u_sp2v_check (
    .sig_i ( chk_in     ),
    .sig_o ( chk_out    ),
    .err_o ( sp_enc_err )
  );

  assign sp_in_valid  = chk_out[0];
  assign sp_out_ready = chk_out[1];
  assign sp_crypt     = chk_out[2];
  assign sp_crypt_q   = chk_out[3];

  ////////////////////////////////////////////////////////////////////////////
  // FSM rails
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < Sp2VWidth; i++) begin : gen_rail
    cipher_rail_fsm #(
      .ActiveHigh    ( SP2V_LOGIC_HIGH[i] ),
      .CiphOpFwdOnly ( CiphOpFwdOnly      )
    ) u_rail (
      .clk_i       ( clk_i           ),
      .rst_ni      ( rst_ni          ),
      .in_valid_i  ( sp_in_valid[i]  ),
      .crypt_i     ( sp_crypt[i]     ),
      .out_ready_i ( sp_out_ready[i] ),
      .crypt_q_i   ( sp_crypt_q[i]   ),
      .cfg_valid_i ( cfg_valid_i     ),
      .op_i        ( op_i            ),
      .key_len_i   ( key_len_i       ),
      .fault_i     ( fault           ),
      .in_ready_o  ( sp_in_ready[i]  ),
      .out_valid_o ( sp_out_valid[i] ),
      .state_we_o  ( sp_state_we[i]  ),
      .crypt_d_o   ( sp_crypt_d[i]   ),
      .sel_o       ( mr_sel[i]       ),   // OR-combined
      .rnd_ctr_o   ( mr_rnd_ctr[i]   ),   // OR-combined
      .alert_o     ( mr_alert[i]     )
    );
  end

  assign in_ready_o  = sp2v_e'(sp_in_ready);
  assign out_valid_o = sp2v_e'(sp_out_valid);
  assign state_we_o  = sp2v_e'(sp_state_we);
  assign alert_o     = |mr_alert;

  rail_or_check #(
    .payload_t ( ciph_sel_t ),
    .NumRails  ( Sp2VWidth  )
  ) u_sel_or_check (
    .rails_i ( mr_sel  ),
    .comb_o  ( sel_o   ),
    .err_o   ( sel_err )
  );

  rail_or_check #(
    .payload_t ( rnd_ctr_t ),
    .NumRails  ( Sp2VWidth )
  ) u_ctr_or_check (
    .rails_i ( mr_rnd_ctr ),
    .comb_o  ( rnd_ctr_o  ),
    .err_o   ( ctr_err    )
  );

  // Every rail sees every fault
  assign fault = sp_enc_err | sel_err | ctr_err;

  // Busy status, checked again on the way back to the rails
  always_ff @(posedge clk_i or negedge rst_ni) begin : crypt_reg
    if (!rst_ni) begin
      crypt_q_raw <= SP2V_LOW;
    end else begin
      crypt_q_raw <= sp_crypt_d;
    end
  end

  assign crypt_o = chk_out[3];

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // A bad operation is only tolerated if the rails trap it
  op_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cfg_valid_i |-> (op_i inside {CIPH_FWD, CIPH_INV}) or (##1 alert_o));

  alert_sticky_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_o |=> alert_o);

endmodule

// ==== verification/cipher_ctrl_checks.svh ====
/*
 * Compare tasks for the cipher controller testbench, one per DUT result
 * type. Included inside the testbench module; the first error ends the run.
 */
`ifndef CIPHER_CTRL_CHECKS_SVH
`define CIPHER_CTRL_CHECKS_SVH

  // Print the error line, then stop
  task automatic report_failure(input string line);
    $display("%s", line);
    $display("Simulation FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_sp2v(input string name, input sp2v_e act, input sp2v_e exp);
    if (act !== exp) begin
      report_failure($sformatf("MISMATCH %s: expected 0x%0h, got 0x%0h", name, exp, act));
    end
  endtask

  // state_only compares just the state register selector
  task automatic check_sel(input string name, input ciph_sel_t act, input ciph_sel_t exp,
                           input bit state_only);
    if (state_only) begin
      if (act.state_sel !== exp.state_sel) begin
        report_failure($sformatf("MISMATCH %s.state_sel: expected 0x%0h, got 0x%0h",
                                 name, exp.state_sel, act.state_sel));
      end
    end else if (act !== exp) begin
      report_failure($sformatf("MISMATCH %s: expected 0x%0h, got 0x%0h", name, exp, act));
    end
  endtask

  task automatic check_ctr(input string name, input rnd_ctr_t act, input rnd_ctr_t exp);
    if (act !== exp) begin
      report_failure($sformatf("MISMATCH %s: expected 0x%0h, got 0x%0h", name, exp, act));
    end
  endtask

  task automatic check_alert(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      report_failure($sformatf("MISMATCH %s: expected 0x%0h, got 0x%0h", name, exp, act));
    end
  endtask

`endif

// ==== verification/cipher_ctrl_tb.sv ====
`timescale 1ns/1ps

/*
 * Testbench for the cipher round controller. Applies a table of key length,
 * operation and back-pressure rows, then injects encoding and op faults.
 */
module cipher_ctrl_tb;

  import cipher_ctrl_pkg::*;

  localparam bit         FwdOnly        = 1'b0;
  localparam int         NumRows        = 8;
  localparam int         WatchdogCycles = (NumRows + 2) * 40;  // Rows plus two fault runs
  localparam logic [3:0] RandBp         = 4'hf;                // Stall length from $urandom

  typedef struct packed {
    key_len_e   key_len;
    ciph_op_e   op;
    logic [3:0] bp_cycles;
  } stim_row_t;

  localparam stim_row_t StimTable [NumRows] = '{
    '{AES_128, CIPH_FWD, 4'd0},
    '{AES_128, CIPH_INV, 4'd2},
    '{AES_192, CIPH_FWD, RandBp},
    '{AES_192, CIPH_INV, 4'd0},
    '{AES_256, CIPH_FWD, 4'd3},
    '{AES_256, CIPH_INV, RandBp},
    '{AES_128, CIPH_INV, RandBp},
    '{AES_256, CIPH_FWD, RandBp}
  };

  logic      clk;
  logic      rst_n;
  sp2v_e     in_valid, in_ready, out_valid, out_ready;
  sp2v_e     crypt_in, crypt_out, state_we;
  logic      cfg_valid;
  ciph_op_e  op;
  key_len_e  key_len;
  ciph_sel_t sel;
  rnd_ctr_t  rnd_ctr;
  logic      alert;

  `include "cipher_ctrl_checks.svh"

  cipher_ctrl_top #(
    .CiphOpFwdOnly ( FwdOnly )
  ) i_dut (
    .clk_i       ( clk       ),
    .rst_ni      ( rst_n     ),
    .in_valid_i  ( in_valid  ),
    .in_ready_o  ( in_ready  ),
    .out_valid_o ( out_valid ),
    .out_ready_i ( out_ready ),
    .cfg_valid_i ( cfg_valid ),
    .op_i        ( op        ),
    .key_len_i   ( key_len   ),
    .crypt_i     ( crypt_in  ),
    .crypt_o     ( crypt_out ),
    .state_we_o  ( state_we  ),
    .sel_o       ( sel       ),
    .rnd_ctr_o   ( rnd_ctr   ),
    .alert_o     ( alert     )
  );

  initial begin : clk_gen
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Expected values
  ////////////////////////////////////////////////////////////////////////////

  function automatic int num_rounds(input key_len_e kl);
    case (kl)
      AES_192: return 12;
      AES_256: return 14;
      default: return 10;
    endcase
  endfunction

  function automatic ciph_sel_t make_sel(input state_sel_e st, input add_rk_sel_e ark,
                                         input round_key_sel_e rk);
    ciph_sel_t s;
    s.state_sel     = st;
    s.add_rk_sel    = ark;
    s.round_key_sel = rk;
    return s;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Sequences
  ////////////////////////////////////////////////////////////////////////////

  task automatic apply_reset();
    in_valid  = SP2V_LOW;
    out_ready = SP2V_LOW;
    crypt_in  = SP2V_LOW;
    cfg_valid = 1'b0;
    op        = CIPH_FWD;
    key_len   = AES_128;
    rst_n     = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n     = 1'b1;
  endtask

  task automatic check_reset_values();
    @(negedge clk);
    check_sp2v("in_ready_o", in_ready, SP2V_LOW);
    check_sp2v("out_valid_o", out_valid, SP2V_LOW);
    check_sp2v("state_we_o", state_we, SP2V_LOW);
    check_sp2v("crypt_o", crypt_out, SP2V_LOW);
    check_alert("alert_o", alert, 1'b0);
    check_sel("sel_o", sel, make_sel(STATE_CLEAR, ADD_RK_INIT, ROUND_KEY_DIRECT), 1'b1);
    crypt_in = SP2V_HIGH;     // Request a run, idle turns ready
    @(negedge clk);
    check_sp2v("in_ready_o", in_ready, SP2V_HIGH);
  endtask

  task automatic run_block(input stim_row_t row);
    int             nr;
    int             bp;
    round_key_sel_e rk_mid;
    ciph_sel_t      exp_sel;
    nr     = num_rounds(row.key_len);
    rk_mid = (row.op == CIPH_INV && !FwdOnly) ? ROUND_KEY_MIXED : ROUND_KEY_DIRECT;
    bp     = (row.bp_cycles == RandBp) ? int'($urandom_range(1, 6)) : int'(row.bp_cycles);

    // Accept cycle
    @(negedge clk);
    check_sp2v("in_ready_o", in_ready, SP2V_HIGH);
    check_sp2v("state_we_o", state_we, SP2V_LOW);
    in_valid  = SP2V_HIGH;
    cfg_valid = 1'b1;
    op        = row.op;
    key_len   = row.key_len;

    // Nr+1 writes, then the result shows up
    for (int cyc = 1; cyc <= nr + 2; cyc++) begin
      @(negedge clk);
      check_sp2v("in_ready_o", in_ready, SP2V_LOW);
      check_sp2v("crypt_o", crypt_out, SP2V_HIGH);
      if (cyc == nr + 2) begin
        check_sp2v("out_valid_o", out_valid, SP2V_HIGH);
        check_sp2v("state_we_o", state_we, SP2V_LOW);
      end else begin
        check_sp2v("out_valid_o", out_valid, SP2V_LOW);
        check_sp2v("state_we_o", state_we, SP2V_HIGH);
        if (cyc == 1) begin
          exp_sel = make_sel(STATE_INIT, ADD_RK_INIT, ROUND_KEY_DIRECT);
        end else if (cyc == nr + 1) begin
          exp_sel = make_sel(STATE_ROUND, ADD_RK_FINAL, ROUND_KEY_DIRECT);
        end else begin
          exp_sel = make_sel(STATE_ROUND, ADD_RK_ROUND, rk_mid);
          check_ctr("rnd_ctr_o", rnd_ctr, rnd_ctr_t'(cyc - 1));
        end
        check_sel("sel_o", sel, exp_sel, 1'b0);
      end
      in_valid  = SP2V_LOW;
      cfg_valid = 1'b0;
    end

    // Consumer stalls
    repeat (bp) begin
      @(negedge clk);
      check_sp2v("out_valid_o", out_valid, SP2V_HIGH);
      check_sp2v("state_we_o", state_we, SP2V_LOW);
      check_sp2v("in_ready_o", in_ready, SP2V_LOW);
      check_sp2v("crypt_o", crypt_out, SP2V_HIGH);
    end
    out_ready = SP2V_HIGH;
    @(negedge clk);
    check_sp2v("out_valid_o", out_valid, SP2V_LOW);
    check_sp2v("crypt_o", crypt_out, SP2V_LOW);
    check_sp2v("in_ready_o", in_ready, SP2V_HIGH);
    out_ready = SP2V_LOW;
  endtask

  // Bad in_valid_i encoding, or bad op_i when bad_op is set
  task automatic run_fault(input bit bad_op);
    apply_reset();
    check_reset_values();
    check_alert("alert_o", alert, 1'b0);
    if (bad_op) begin
      cfg_valid = 1'b1;
      op        = ciph_op_e'(2'b11);
    end else begin
      in_valid  = sp2v_e'(3'b111);
    end
    @(negedge clk);
    check_alert("alert_o", alert, 1'b1);
    in_valid  = SP2V_LOW;
    cfg_valid = 1'b0;
    op        = CIPH_FWD;
    // Blocks offered now must be ignored
    repeat (8) begin
      @(negedge clk);
      check_alert("alert_o", alert, 1'b1);
      check_sp2v("in_ready_o", in_ready, SP2V_LOW);
      check_sp2v("out_valid_o", out_valid, SP2V_LOW);
      check_sp2v("state_we_o", state_we, SP2V_LOW);
      in_valid  = SP2V_HIGH;
      cfg_valid = 1'b1;
      out_ready = SP2V_HIGH;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main_seq
    void'($urandom(8997));    // Seed the thread RNG once
    apply_reset();
    check_reset_values();
    for (int i = 0; i < NumRows; i++) begin
      run_block(StimTable[i]);
    end
    run_fault(1'b0);
    run_fault(1'b1);
    $display("Simulation PASSED");
    $finish;
  end

  initial begin : watchdog
    repeat (WatchdogCycles) @(posedge clk);
    report_failure($sformatf("Timeout, run did not finish within %0d cycles",
                             WatchdogCycles));
  end

endmodule

// ==== build.f ====
+incdir+verification
common/cipher_ctrl_pkg.sv
cipher_ctrl/sp2v_check.sv
cipher_ctrl/rail_or_check.sv
cipher_ctrl/cipher_rail_fsm.sv
cipher_ctrl/cipher_ctrl_top.sv
verification/cipher_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: cipher_ctrl

sources:
  # Shared package first, then the controller blocks
  - files:
      - common/cipher_ctrl_pkg.sv
      - cipher_ctrl/sp2v_check.sv
      - cipher_ctrl/rail_or_check.sv
      - cipher_ctrl/cipher_rail_fsm.sv
      - cipher_ctrl/cipher_ctrl_top.sv

  # Testbench, top module cipher_ctrl_tb
  - target: test
    include_dirs:
      - verification
    files:
      - verification/cipher_ctrl_tb.sv
